/* design/cp0Pkg.sv */
package cp0Pkg;

    // --------------------------------------------------
    // widths and constants
    // --------------------------------------------------
    localparam int WORD_W     = 32;
    localparam int EXC_CODE_W = 5;
    localparam int CP0_ADDR_W = 8;
    localparam int EXT_INT_W  = 6;

    // general exception entry, BEV is hardwired to 1
    localparam logic [WORD_W-1:0] EXC_VECTOR = 32'hbfc00380;

    // register addresses, {rd, sel}
    localparam logic [CP0_ADDR_W-1:0] ADDR_BADVADDR = {5'd8, 3'd0};
    localparam logic [CP0_ADDR_W-1:0] ADDR_COUNT    = {5'd9, 3'd0};
    localparam logic [CP0_ADDR_W-1:0] ADDR_COMPARE  = {5'd11, 3'd0};
    localparam logic [CP0_ADDR_W-1:0] ADDR_STATUS   = {5'd12, 3'd0};
    localparam logic [CP0_ADDR_W-1:0] ADDR_CAUSE    = {5'd13, 3'd0};
    localparam logic [CP0_ADDR_W-1:0] ADDR_EPC      = {5'd14, 3'd0};

    // address-class codes, these load BadVAddr
    localparam logic [EXC_CODE_W-1:0] EXC_MOD  = 5'd1;
    localparam logic [EXC_CODE_W-1:0] EXC_TLBL = 5'd2;
    localparam logic [EXC_CODE_W-1:0] EXC_TLBS = 5'd3;
    localparam logic [EXC_CODE_W-1:0] EXC_ADEL = 5'd4;
    localparam logic [EXC_CODE_W-1:0] EXC_ADES = 5'd5;

    // --------------------------------------------------
    // pipeline-facing types
    // --------------------------------------------------
    // one record per stage, 73 bits
    typedef struct packed {
        logic                  hasExc;
        logic [EXC_CODE_W-1:0] excCode;
        logic                  isDelaySlot;
        logic [WORD_W-1:0]     pc;
        logic [WORD_W-1:0]     badVAddr;
        logic                  nonBlockMark;
        logic                  eret;
    } stageExc_t;

    // mtc0 command; addr also drives the mfc0 read
    typedef struct packed {
        logic                  wen;
        logic [CP0_ADDR_W-1:0] addr;
        logic [WORD_W-1:0]     data;
    } cp0Write_t;

    typedef enum logic [1:0] {
        SEG_NONE   = 2'd0,
        SEG_EXE    = 2'd1,
        SEG_PREMEM = 2'd2,
        SEG_MEM    = 2'd3
    } excSeg_e;

    // --------------------------------------------------
    // register word layouts
    // --------------------------------------------------
    typedef struct packed {
        logic [8:0] rsvdHi;
        logic       bev;
        logic [5:0] rsvdMid;
        logic [7:0] im;
        logic [5:0] rsvdLo;
        logic       exl;
        logic       ie;
    } statusBits_t;

    typedef struct packed {
        logic                  bd;
        logic                  ti;
        logic [13:0]           rsvdHi;
        logic [7:0]            ip;
        logic                  rsvdMid;
        logic [EXC_CODE_W-1:0] excCode;
        logic [1:0]            rsvdLo;
    } causeBits_t;

    // same 32-bit word seen as Status or as Cause
    typedef union packed {
        logic [WORD_W-1:0] raw;
        statusBits_t       status;
        causeBits_t        cause;
    } cp0Word_u;

endpackage

/* design/excSelect.sv */
`timescale 1ns/1ps

module excSelect (
    input  cp0Pkg::stageExc_t exeInfo_i,
    input  cp0Pkg::stageExc_t preMemInfo_i,
    input  cp0Pkg::stageExc_t memInfo_i,
    input  logic              preMemRisk_i,
    input  logic              memRisk_i,
    input  logic              wbRisk_i,
    input  logic              exl_i,
    output cp0Pkg::stageExc_t sel_o,
    output cp0Pkg::excSeg_e   seg_o,
    output logic              takeExc_o
);
    import cp0Pkg::*;

    // --------------------------------------------------
    // oldest stage whose successors carry no risk
    // --------------------------------------------------
    // a stage may only take the exception when everything
    // younger than it in flight is already safe to drop
    always_comb begin
        if (!preMemRisk_i) begin
            sel_o = exeInfo_i;
            seg_o = SEG_EXE;
        end
        else if (!memRisk_i) begin
            sel_o = preMemInfo_i;
            seg_o = SEG_PREMEM;
        end
        else if (!wbRisk_i) begin
            sel_o = memInfo_i;
            seg_o = SEG_MEM;
        end
        else begin
            sel_o = '0;
            seg_o = SEG_NONE;
        end
    end

    // masked while already in the handler
    assign takeExc_o = sel_o.hasExc & ~exl_i;

endmodule

/* design/cp0StatusCause.sv */
`timescale 1ns/1ps

module cp0StatusCause (
    input  logic                              clk,
    input  logic                              rst,
    input  cp0Pkg::cp0Write_t                 cp0Wr_i,
    input  cp0Pkg::stageExc_t                 sel_i,
    input  logic                              takeExc_i,
    input  logic                              timerInt_i,
    input  logic [cp0Pkg::EXT_INT_W-1:0]      extInt_i,
    output cp0Pkg::cp0Word_u                  status_o,
    output cp0Pkg::cp0Word_u                  cause_o,
    output logic                              exl_o
);
    import cp0Pkg::*;

    cp0Word_u              wrWord;
    logic                  statusWen;
    logic                  causeWen;
    logic [7:0]            im;
    logic                  exl;
    logic                  ie;
    logic                  bd;
    logic [EXC_CODE_W-1:0] excCode;
    logic [EXT_INT_W-1:0]  extIntQ;
    logic [1:0]            swIp;

    // mtc0 data seen through the union
    assign wrWord.raw = cp0Wr_i.data;
    assign statusWen  = cp0Wr_i.wen && (cp0Wr_i.addr == ADDR_STATUS);
    assign causeWen   = cp0Wr_i.wen && (cp0Wr_i.addr == ADDR_CAUSE);

    // --------------------------------------------------
    // Status
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            im <= '0;
            ie <= 1'b0;
        end
        else if (statusWen) begin
            im <= wrWord.status.im;
            ie <= wrWord.status.ie;
        end
    end

    // software write beats exception entry beats eret
    always_ff @(posedge clk) begin
        if (!rst) begin
            exl <= 1'b0;
        end
        else if (statusWen) begin
            exl <= wrWord.status.exl;
        end
        else if (takeExc_i) begin
            exl <= 1'b1;
        end
        else if (sel_i.eret) begin
            exl <= 1'b0;
        end
    end

    // --------------------------------------------------
    // Cause
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            bd      <= 1'b0;
            excCode <= '0;
        end
        else if (takeExc_i) begin
            bd      <= sel_i.isDelaySlot;
            excCode <= sel_i.excCode;
        end
    end

    // hardware lines sampled every cycle, soft bits only by mtc0
    always_ff @(posedge clk) begin
        if (!rst) begin
            extIntQ <= '0;
            swIp    <= '0;
        end
        else begin
            extIntQ <= extInt_i;
            if (causeWen) begin
                swIp <= wrWord.cause.ip[1:0];
            end
        end
    end

    always_comb begin
        status_o            = '0;
        status_o.status.bev = 1'b1;
        status_o.status.im  = im;
        status_o.status.exl = exl;
        status_o.status.ie  = ie;

        cause_o               = '0;
        cause_o.cause.bd      = bd;
        cause_o.cause.ti      = timerInt_i;
        // IP7 shared by ext line 5 and the timer
        cause_o.cause.ip      = {extIntQ[5] | timerInt_i, extIntQ[4:0], swIp};
        cause_o.cause.excCode = excCode;
    end

    assign exl_o = exl;

endmodule

/* design/cp0Timer.sv */
`timescale 1ns/1ps

module cp0Timer (
    input  logic                          clk,
    input  logic                          rst,
    input  cp0Pkg::cp0Write_t             cp0Wr_i,
    output logic [cp0Pkg::WORD_W-1:0]     count_o,
    output logic [cp0Pkg::WORD_W-1:0]     compare_o,
    output logic                          timerInt_o
);
    import cp0Pkg::*;

    logic              tickPhase;
    logic [WORD_W-1:0] count;
    logic [WORD_W-1:0] compare;
    logic              ti;
    logic              countWen;
    logic              compareWen;

    assign countWen   = cp0Wr_i.wen && (cp0Wr_i.addr == ADDR_COUNT);
    assign compareWen = cp0Wr_i.wen && (cp0Wr_i.addr == ADDR_COMPARE);

    // --------------------------------------------------
    // half-rate count
    // --------------------------------------------------
    // phase runs freely, a Count write leaves it alone
    always_ff @(posedge clk) begin
        if (!rst) begin
            tickPhase <= 1'b0;
        end
        else begin
            tickPhase <= ~tickPhase;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            count <= '0;
        end
        else if (countWen) begin
            count <= cp0Wr_i.data;
        end
        else if (tickPhase) begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            compare <= '0;
        end
        else if (compareWen) begin
            compare <= cp0Wr_i.data;
        end
    end

    // clear on Compare write wins over a match
    always_ff @(posedge clk) begin
        if (!rst) begin
            ti <= 1'b0;
        end
        else if (compareWen) begin
            ti <= 1'b0;
        end
        else if (count == compare) begin
            ti <= 1'b1;
        end
    end

    assign count_o    = count;
    assign compare_o  = compare;
    assign timerInt_o = ti;

endmodule

/* design/cp0ExcRegs.sv */
`timescale 1ns/1ps

module cp0ExcRegs (
    input  logic                          clk,
    input  logic                          rst,
    input  cp0Pkg::cp0Write_t             cp0Wr_i,
    input  cp0Pkg::stageExc_t             sel_i,
    input  logic                          takeExc_i,
    output logic [cp0Pkg::WORD_W-1:0]     epc_o,
    output logic [cp0Pkg::WORD_W-1:0]     badVAddr_o
);
    import cp0Pkg::*;

    logic [WORD_W-1:0] epc;
    logic [WORD_W-1:0] badVAddr;
    logic [WORD_W-1:0] retPc;
    logic              addrClass;
    logic              epcWen;

    // return to the branch when the fault sits in its delay slot
    assign retPc     = sel_i.isDelaySlot ? (sel_i.pc - 32'd4) : sel_i.pc;
    assign addrClass = sel_i.excCode inside {EXC_MOD, EXC_TLBL, EXC_TLBS, EXC_ADEL, EXC_ADES};
    assign epcWen    = cp0Wr_i.wen && (cp0Wr_i.addr == ADDR_EPC);

    always_ff @(posedge clk) begin
        if (!rst) begin
            epc <= '0;
        end
        else if (takeExc_i) begin
            epc <= retPc;
        end
        else if (epcWen) begin
            epc <= cp0Wr_i.data;
        end
    end

    // read-only to software
    always_ff @(posedge clk) begin
        if (!rst) begin
            badVAddr <= '0;
        end
        else if (takeExc_i && addrClass) begin
            badVAddr <= sel_i.badVAddr;
        end
    end

    assign epc_o      = epc;
    assign badVAddr_o = badVAddr;

endmodule

/* design/cp0Top.sv */
`timescale 1ns/1ps

module cp0Top (
    input  logic                          clk,
    input  logic                          rst,
    input  cp0Pkg::stageExc_t             exeInfo_i,
    input  cp0Pkg::stageExc_t             preMemInfo_i,
    input  cp0Pkg::stageExc_t             memInfo_i,
    input  logic                          preMemRisk_i,
    input  logic                          memRisk_i,
    input  logic                          wbRisk_i,
    input  cp0Pkg::cp0Write_t             cp0Wr_i,
    input  logic [cp0Pkg::EXT_INT_W-1:0]  extInt_i,
    output logic [cp0Pkg::WORD_W-1:0]     readData_o,
    output logic                          excOccur_o,
    output logic [cp0Pkg::WORD_W-1:0]     excDestPc_o,
    output logic                          nonBlockMark_o,
    output cp0Pkg::excSeg_e               excSeg_o,
    output cp0Pkg::cp0Word_u              status_o,
    output cp0Pkg::cp0Word_u              cause_o
);
    import cp0Pkg::*;

    stageExc_t         sel;
    logic              takeExc;
    logic              exl;
    logic              timerInt;
    logic [WORD_W-1:0] count;
    logic [WORD_W-1:0] compare;
    logic [WORD_W-1:0] epc;
    logic [WORD_W-1:0] badVAddr;

    // --------------------------------------------------
    // sub-blocks
    // --------------------------------------------------
    excSelect u_excSelect (
        .exeInfo_i    (exeInfo_i),
        .preMemInfo_i (preMemInfo_i),
        .memInfo_i    (memInfo_i),
        .preMemRisk_i (preMemRisk_i),
        .memRisk_i    (memRisk_i),
        .wbRisk_i     (wbRisk_i),
        .exl_i        (exl),
        .sel_o        (sel),
        .seg_o        (excSeg_o),
        .takeExc_o    (takeExc)
    );

    cp0StatusCause u_statusCause (
        .clk        (clk),
        .rst        (rst),
        .cp0Wr_i    (cp0Wr_i),
        .sel_i      (sel),
        .takeExc_i  (takeExc),
        .timerInt_i (timerInt),
        .extInt_i   (extInt_i),
        .status_o   (status_o),
        .cause_o    (cause_o),
        .exl_o      (exl)
    );

    cp0Timer u_timer (
        .clk        (clk),
        .rst        (rst),
        .cp0Wr_i    (cp0Wr_i),
        .count_o    (count),
        .compare_o  (compare),
        .timerInt_o (timerInt)
    );

    cp0ExcRegs u_excRegs (
        .clk        (clk),
        .rst        (rst),
        .cp0Wr_i    (cp0Wr_i),
        .sel_i      (sel),
        .takeExc_i  (takeExc),
        .epc_o      (epc),
        .badVAddr_o (badVAddr)
    );

    // --------------------------------------------------
    // mfc0 read and redirect
    // --------------------------------------------------
    always_comb begin
        case (cp0Wr_i.addr)
            ADDR_STATUS:   readData_o = status_o.raw;
            ADDR_CAUSE:    readData_o = cause_o.raw;
            ADDR_EPC:      readData_o = epc;
            ADDR_BADVADDR: readData_o = badVAddr;
            ADDR_COUNT:    readData_o = count;
            ADDR_COMPARE:  readData_o = compare;
            default:       readData_o = '0;
        endcase
    end

    // exception entry outranks eret for the target
    assign excOccur_o  = takeExc | sel.eret;
    assign excDestPc_o = takeExc  ? EXC_VECTOR :
                         sel.eret ? epc        : '0;

    assign nonBlockMark_o = sel.nonBlockMark;

endmodule

/* dv/cp0Top_chk.sv */
`timescale 1ns/1ps

module cp0Top_chk (
    input logic                          clk,
    input logic                          rst,
    input cp0Pkg::stageExc_t             exeInfo_i,
    input cp0Pkg::stageExc_t             preMemInfo_i,
    input cp0Pkg::stageExc_t             memInfo_i,
    input logic                          preMemRisk_i,
    input logic                          memRisk_i,
    input logic                          wbRisk_i,
    input logic                          takeExc_i,
    input cp0Pkg::cp0Write_t             cp0Wr_i,
    input logic                          excOccur_i,
    input logic [cp0Pkg::WORD_W-1:0]     excDestPc_i,
    input cp0Pkg::excSeg_e               excSeg_i,
    input cp0Pkg::cp0Word_u              status_i
);
    import cp0Pkg::*;

    logic statusWen;
    logic allRisk;
    logic selHasExc;

    assign statusWen = cp0Wr_i.wen && (cp0Wr_i.addr == ADDR_STATUS);

    // stage choice taken straight from the pipeline inputs
    assign allRisk   = preMemRisk_i && memRisk_i && wbRisk_i;
    assign selHasExc = !preMemRisk_i ? exeInfo_i.hasExc    :
                       !memRisk_i    ? preMemInfo_i.hasExc :
                       !wbRisk_i     ? memInfo_i.hasExc    : 1'b0;

    // --------------------------------------------------
    // redirect rules
    // --------------------------------------------------
    resetQuiet: assert property (@(posedge clk) !rst |-> !excOccur_i)
        else $error("redirect raised while reset is asserted");

    noSegNoRedirect: assert property (@(posedge clk) disable iff (!rst)
        allRisk |-> ((excSeg_i == SEG_NONE) && !excOccur_i))
        else $error("redirect raised with no stage selected");

    vectorOnEntry: assert property (@(posedge clk) disable iff (!rst)
        (selHasExc && !status_i.status.exl) |->
            (excOccur_i && (excDestPc_i == EXC_VECTOR)))
        else $error("taken exception does not target the exception vector");

    // a same-cycle Status write owns EXL
    exlAfterEntry: assert property (@(posedge clk) disable iff (!rst)
        (takeExc_i && !statusWen) |=> status_i.status.exl)
        else $error("EXL not set one cycle after a taken exception");

endmodule

bind cp0Top cp0Top_chk u_chk (
    .clk          (clk),
    .rst          (rst),
    .exeInfo_i    (exeInfo_i),
    .preMemInfo_i (preMemInfo_i),
    .memInfo_i    (memInfo_i),
    .preMemRisk_i (preMemRisk_i),
    .memRisk_i    (memRisk_i),
    .wbRisk_i     (wbRisk_i),
    .takeExc_i    (takeExc),
    .cp0Wr_i      (cp0Wr_i),
    .excOccur_i   (excOccur_o),
    .excDestPc_i  (excDestPc_o),
    .excSeg_i     (excSeg_o),
    .status_i     (status_o)
);

/* dv/cp0Tb.sv */
`timescale 1ns/1ps

module cp0Tb;
    import cp0Pkg::*;

    logic                 clk;
    logic                 rst;
    stageExc_t            exeInfo;
    stageExc_t            preMemInfo;
    stageExc_t            memInfo;
    logic                 preMemRisk;
    logic                 memRisk;
    logic                 wbRisk;
    cp0Write_t            cp0Wr;
    logic [EXT_INT_W-1:0] extInt;
    logic [WORD_W-1:0]    readData;
    logic                 excOccur;
    logic [WORD_W-1:0]    excDestPc;
    logic                 nonBlockMark;
    excSeg_e              excSeg;
    cp0Word_u             status;
    cp0Word_u             cause;

    int                   errors;
    int                   timeouts;
    int                   fd;
    logic [31:0]          lcgState;
    // TI as the timer rules predict it
    logic                 timerSet;

    cp0Top u_dut (
        .clk            (clk),
        .rst            (rst),
        .exeInfo_i      (exeInfo),
        .preMemInfo_i   (preMemInfo),
        .memInfo_i      (memInfo),
        .preMemRisk_i   (preMemRisk),
        .memRisk_i      (memRisk),
        .wbRisk_i       (wbRisk),
        .cp0Wr_i        (cp0Wr),
        .extInt_i       (extInt),
        .readData_o     (readData),
        .excOccur_o     (excOccur),
        .excDestPc_o    (excDestPc),
        .nonBlockMark_o (nonBlockMark),
        .excSeg_o       (excSeg),
        .status_o       (status),
        .cause_o        (cause)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic checkWord(input string name, input logic [WORD_W-1:0] exp,
                             input logic [WORD_W-1:0] act);
        if (act !== exp) begin
            $display("Error: %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic checkReg(input string name, input cp0Word_u exp, input cp0Word_u act);
        if (act.raw !== exp.raw) begin
            $display("Error: %s expected %h actual %h", name, exp.raw, act.raw);
            errors++;
        end
    endtask

    task automatic checkSeg(input string name, input excSeg_e exp, input excSeg_e act);
        if (act !== exp) begin
            $display("Error: %s expected %s actual %s", name, exp.name(), act.name());
            errors++;
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error: %s expected %b actual %b", name, exp, act);
            errors++;
        end
    endtask

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic bit fieldsOk(input string op, input int got, input int want);
        if (got != want) begin
            $display("Stimulus line %s has %0d fields where %0d were expected", op, got, want);
            errors++;
            return 1'b0;
        end
        return 1'b1;
    endfunction

    // --------------------------------------------------
    // one operation per clock, driven on the falling edge
    // --------------------------------------------------
    task automatic startCycle();
        @(negedge clk);
        cp0Wr.wen  = 1'b0;
        exeInfo    = '0;
        preMemInfo = '0;
        memInfo    = '0;
        preMemRisk = 1'b0;
        memRisk    = 1'b0;
        wbRisk     = 1'b0;
    endtask

    task automatic doWrite(input logic [CP0_ADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
        startCycle();
        cp0Wr.wen  = 1'b1;
        cp0Wr.addr = addr;
        cp0Wr.data = data;
        if (addr == ADDR_COMPARE) begin
            timerSet = 1'b0;
        end
    endtask

    task automatic doRead(input logic [CP0_ADDR_W-1:0] addr, input logic [WORD_W-1:0] exp);
        startCycle();
        cp0Wr.addr = addr;
        #1;
        checkWord($sformatf("mfc0 addr %h", addr), exp, readData);
    endtask

    task automatic doExc(input logic [1:0] stage, input logic [2:0] risk,
                         input logic [EXC_CODE_W-1:0] code, input logic ds,
                         input logic [WORD_W-1:0] pc, input logic [WORD_W-1:0] bad,
                         input logic expOcc, input logic [WORD_W-1:0] expDest,
                         input logic [1:0] expSeg);
        stageExc_t rec;
        rec              = '0;
        rec.hasExc       = 1'b1;
        rec.excCode      = code;
        rec.isDelaySlot  = ds;
        rec.pc           = pc;
        rec.badVAddr     = bad;
        rec.nonBlockMark = 1'b1;
        startCycle();
        case (stage)
            2'd0:    exeInfo = rec;
            2'd1:    preMemInfo = rec;
            default: memInfo = rec;
        endcase
        {preMemRisk, memRisk, wbRisk} = risk;
        #1;
        checkBit("exc occur", expOcc, excOccur);
        checkWord("exc dest pc", expDest, excDestPc);
        checkSeg("exc segment", excSeg_e'(expSeg), excSeg);
        // mark only comes through when the loaded stage is the chosen one
        checkBit("exc nonblock mark", expSeg == stage + 2'd1, nonBlockMark);
    endtask

    task automatic doEret(input logic [WORD_W-1:0] expDest);
        startCycle();
        exeInfo.eret = 1'b1;
        #1;
        checkBit("eret occur", 1'b1, excOccur);
        checkWord("eret dest pc", expDest, excDestPc);
    endtask

    task automatic doInt(input logic [EXT_INT_W-1:0] ext);
        logic [5:0] expIp;
        startCycle();
        extInt = ext;
        startCycle();
        #1;
        // IP7 shared by line 5 and the timer
        expIp = {ext[5] | timerSet, ext[4:0]};
        checkWord($sformatf("Cause IP for extInt %h", ext), {26'd0, expIp},
                  {26'd0, cause.cause.ip[7:2]});
    endtask

    task automatic doTimer(input logic [WORD_W-1:0] offset);
        logic seen;
        int   waited;
        seen   = 1'b0;
        waited = 0;
        doWrite(ADDR_COUNT, 32'h00001000);
        doWrite(ADDR_COMPARE, 32'h00001000 + offset);
        while (!seen && waited < 64) begin
            startCycle();
            #1;
            seen = cause.cause.ti;
            waited++;
        end
        if (!seen) begin
            $display("Timeout: timer interrupt did not set within 64 cycles of Compare write");
            timeouts++;
        end
        else begin
            timerSet = 1'b1;
            checkBit("timer IP7", 1'b1, cause.cause.ip[7]);
        end
        doWrite(ADDR_COMPARE, 32'hffffffff);
        startCycle();
        #1;
        checkBit("timer clear on Compare write", 1'b0, cause.cause.ti);
    endtask

    // entry, register check and eret from the EXE stage, three cycles each
    task automatic doRandomExc(input int n);
        stageExc_t         rec;
        logic [31:0]       r;
        logic [WORD_W-1:0] expEpc;
        cp0Word_u          expCause;
        for (int i = 0; i < n; i++) begin
            r               = nextRandom();
            rec             = '0;
            rec.hasExc      = 1'b1;
            rec.excCode     = r[29] ? EXC_ADES : EXC_ADEL;
            rec.isDelaySlot = r[28];
            rec.pc          = 32'h80002000 | {20'd0, r[25:16], 2'b00};
            rec.badVAddr    = nextRandom();
            expEpc          = r[28] ? rec.pc - 32'd4 : rec.pc;

            expCause               = '0;
            expCause.cause.bd      = r[28];
            expCause.cause.ip      = {extInt[5] | timerSet, extInt[4:0], 2'b00};
            expCause.cause.excCode = rec.excCode;

            startCycle();
            exeInfo = rec;
            #1;
            checkBit("random exc EXL clear before entry", 1'b0, status.status.exl);
            checkBit("random exc occur", 1'b1, excOccur);
            checkWord("random exc dest pc", EXC_VECTOR, excDestPc);

            startCycle();
            cp0Wr.addr = ADDR_EPC;
            #1;
            checkWord("random exc EPC", expEpc, readData);
            checkReg("random exc Cause", expCause, cause);
            checkBit("random exc EXL set", 1'b1, status.status.exl);

            startCycle();
            exeInfo.eret = 1'b1;
            cp0Wr.addr   = ADDR_BADVADDR;
            #1;
            checkBit("random eret occur", 1'b1, excOccur);
            checkWord("random eret dest pc", expEpc, excDestPc);
            checkWord("random exc BadVAddr", rec.badVAddr, readData);
        end
        startCycle();
        #1;
        checkBit("random eret EXL clear", 1'b0, status.status.exl);
    endtask

    // --------------------------------------------------
    // stimulus file
    // --------------------------------------------------
    task automatic runFile();
        string       op;
        string       rest;
        logic [31:0] f [9];
        int          got;
        int          opCount;
        bit          done;
        opCount = 0;
        done    = 1'b0;
        while (!done && opCount < 2000) begin
            got = $fscanf(fd, "%s", op);
            if (got != 1) begin
                done = 1'b1;
            end
            else if (op.substr(0, 0) == "#") begin
                got = $fgets(rest, fd);
            end
            else begin
                opCount++;
                case (op)
                    "WR": begin
                        got = $fscanf(fd, "%h %h", f[0], f[1]);
                        if (fieldsOk(op, got, 2)) begin
                            doWrite(f[0][CP0_ADDR_W-1:0], f[1]);
                        end
                    end
                    "RD": begin
                        got = $fscanf(fd, "%h %h", f[0], f[1]);
                        if (fieldsOk(op, got, 2)) begin
                            doRead(f[0][CP0_ADDR_W-1:0], f[1]);
                        end
                    end
                    "EXC": begin
                        got = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                                      f[3], f[4], f[5], f[6], f[7], f[8]);
                        if (fieldsOk(op, got, 9)) begin
                            doExc(f[0][1:0], f[1][2:0], f[2][EXC_CODE_W-1:0], f[3][0],
                                  f[4], f[5], f[6][0], f[7], f[8][1:0]);
                        end
                    end
                    "ERET": begin
                        got = $fscanf(fd, "%h", f[0]);
                        if (fieldsOk(op, got, 1)) begin
                            doEret(f[0]);
                        end
                    end
                    "INT": begin
                        got = $fscanf(fd, "%h", f[0]);
                        if (fieldsOk(op, got, 1)) begin
                            doInt(f[0][EXT_INT_W-1:0]);
                        end
                    end
                    "INTR": begin
                        got = $fscanf(fd, "%h", f[0]);
                        if (fieldsOk(op, got, 1)) begin
                            for (int i = 0; i < f[0]; i++) begin
                                f[1] = nextRandom();
                                doInt(f[1][21:16]);
                            end
                        end
                    end
                    "EXCR": begin
                        got = $fscanf(fd, "%h", f[0]);
                        if (fieldsOk(op, got, 1)) begin
                            doRandomExc(f[0]);
                        end
                    end
                    "TIMER": begin
                        got = $fscanf(fd, "%h", f[0]);
                        if (fieldsOk(op, got, 1)) begin
                            doTimer(f[0]);
                        end
                    end
                    default: begin
                        $display("Unknown operation %s in stimulus file", op);
                        errors++;
                    end
                endcase
            end
        end
    endtask

    initial begin
        errors     = 0;
        timeouts   = 0;
        timerSet   = 1'b0;
        lcgState   = 32'h0d19d466;
        rst        = 1'b0;
        exeInfo    = '0;
        preMemInfo = '0;
        memInfo    = '0;
        preMemRisk = 1'b0;
        memRisk    = 1'b0;
        wbRisk     = 1'b0;
        cp0Wr      = '0;
        extInt     = '0;

        repeat (2) @(negedge clk);
        rst = 1'b1;

        fd = $fopen("dv/cp0_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Stimulus file dv/cp0_stimulus.txt could not be opened");
            errors++;
        end
        else begin
            runFile();
            $fclose(fd);
        end

        $display("errors=%0d timeouts=%0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end
        else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* dv/cp0_stimulus.txt */
# WR addr data | RD addr expData | ERET expDestPc | INT extInt | INTR n | EXCR n | TIMER offset
# EXC stage(0 exe 1 premem 2 mem) risk{pm,m,wb} code ds pc badVAddr expOccur expDestPc expSeg
WR 58 ffffffff
RD 58 ffffffff
WR 60 ffffffff
RD 60 0040ff03
WR 60 0000ff01
RD 60 0040ff01
WR 70 12345678
RD 70 12345678
WR 48 00000100
RD 48 00000100
RD 61 00000000
RD 40 00000000
EXC 0 0 04 0 bfc00100 00000123 1 bfc00380 1
RD 68 00000010
RD 70 bfc00100
RD 40 00000123
EXC 0 0 0c 0 80000000 00000000 0 00000000 1
RD 70 bfc00100
RD 68 00000010
ERET bfc00100
RD 60 0040ff01
EXC 1 5 0c 1 80000204 deadbeef 1 bfc00380 2
RD 68 80000030
RD 70 80000200
RD 40 00000123
ERET 80000200
EXC 2 6 05 0 80000300 00000abc 1 bfc00380 3
RD 40 00000abc
RD 68 00000014
ERET 80000300
EXC 2 7 04 0 80000400 00000fff 0 00000000 0
EXC 0 4 02 0 80000500 00000fff 0 00000000 2
RD 40 00000abc
TIMER 6
INT 2a
INT 15
INTR 8
EXCR 6
INT 00

/* vlog.f */
design/cp0Pkg.sv
design/excSelect.sv
design/cp0StatusCause.sv
design/cp0Timer.sv
design/cp0ExcRegs.sv
design/cp0Top.sv
dv/cp0Top_chk.sv
dv/cp0Tb.sv
